// File: include/axi_mem_macros.svh
/* AXI memory slave build constants
   bus widths, memory depth, transfer slots and the serial stub address */
`ifndef AXI_MEM_MACROS_SVH
`define AXI_MEM_MACROS_SVH

// bus geometry
`define AXI_ID_W 2
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W (`AXI_DATA_W / 8)

// memory array holds 2**MEM_WORDS_LOG2 bus words
`define MEM_WORDS_LOG2 8

// one slot per id in each direction
`define NUM_SLOTS 4

// 8250-style stub, data at offset 0 and line status at offset 5
`define SERIAL_ADDR 32'h1000_0000
`define SERIAL_STAT_ADDR (`SERIAL_ADDR + 32'd5)

`endif

// File: verilog/axi_mem_pkg.sv
/* Shared types for the AXI memory slave
   channel structs, transfer record and the burst address rule */
`include "axi_mem_macros.svh"

package axi_mem_pkg;

    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [7:0]             beat_cnt_t;
    typedef logic [7:0]             serial_byte_t;

    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_t;

    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        beat_cnt_t  len;
        burst_t     burst;
        logic       lock;
        logic [3:0] cache;
    } ax_req_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        logic      last;
    } r_beat_t;

    typedef struct packed {
        logic      valid;
        axi_addr_t addr;
        beat_cnt_t len;
        beat_cnt_t cur;
        burst_t    burst;
    } xfer_t;

    // address of beat t.cur within the burst
    function automatic axi_addr_t burst_addr(xfer_t t);
        axi_addr_t sum;
        axi_addr_t mask;
        sum  = t.addr + axi_addr_t'(t.cur) * axi_addr_t'(`AXI_STRB_W);
        // wrap window is len+1 beats, aligned to its own size
        mask = (axi_addr_t'(t.len) + 1) * axi_addr_t'(`AXI_STRB_W) - 1;
        case (t.burst)
            FIXED:   burst_addr = t.addr;
            WRAP:    burst_addr = (t.addr & ~mask) | (sum & mask);
            default: burst_addr = sum;
        endcase
    endfunction

endpackage

// File: verilog/req_fifo.sv
/* Two-entry valid/ready buffer
   decouples an AXI request or data channel from the slot logic */
module req_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0] entry [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

    // a stalled producer keeps its beat until a slot frees up
    a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

// File: verilog/read_engine.sv
/* AXI read engine
   per-id read slots, beat selection and the registered R channel */
`include "axi_mem_macros.svh"

module read_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_mem_pkg::ax_req_t   ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_mem_pkg::axi_addr_t rd_addr,
    output logic                   rd_en,
    input  axi_mem_pkg::axi_data_t rd_data,
    output axi_mem_pkg::r_beat_t   r,
    output logic                   r_valid,
    input  logic                   r_ready
);

    import axi_mem_pkg::*;

    xfer_t   slots [`NUM_SLOTS];
    axi_id_t sel_id;
    logic    sel_valid;
    logic    sel_last;
    logic    issue;
    logic    load;

    // a busy id holds its request back in the AR buffer
    assign ar_ready = !slots[ar.id].valid;
    assign load     = ar_valid && ar_ready;

    // highest-numbered active slot wins
    always_comb begin
        sel_valid = 1'b0;
        sel_id    = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (slots[i].valid) begin
                sel_valid = 1'b1;
                sel_id    = axi_id_t'(i);
            end
        end
    end

    assign issue    = sel_valid && (!r_valid || r_ready);
    assign sel_last = (slots[sel_id].cur == slots[sel_id].len);
    assign rd_addr  = burst_addr(slots[sel_id]);
    assign rd_en    = issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else begin
            if (issue) begin
                slots[sel_id].cur <= slots[sel_id].cur + 8'd1;
                if (sel_last) begin
                    slots[sel_id].valid <= 1'b0;
                end
            end
            // loaded id is idle, so it never collides with the issue above
            if (load) begin
                slots[ar.id].valid <= 1'b1;
                slots[ar.id].addr  <= ar.addr;
                slots[ar.id].len   <= ar.len;
                slots[ar.id].cur   <= '0;
                slots[ar.id].burst <= ar.burst;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (!r_valid || r_ready) begin
            r_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            r.id   <= sel_id;
            r.data <= rd_data;
            r.last <= sel_last;
        end
    end

    a_wrap_len: assert property (@(posedge clk) disable iff (!rst_n)
        (load && ar.burst == WRAP) |-> (ar.len inside {8'd1, 8'd3, 8'd7, 8'd15}));

endmodule

// File: verilog/write_engine.sv
/* AXI write engine
   per-id write slots, AW order queue, W beat steering and in-order B */
`include "axi_mem_macros.svh"

module write_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_mem_pkg::ax_req_t   aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_mem_pkg::w_beat_t   w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_mem_pkg::axi_addr_t wr_addr,
    output axi_mem_pkg::axi_data_t wr_data,
    output axi_mem_pkg::axi_strb_t wr_strb,
    output logic                   wr_en,
    output axi_mem_pkg::axi_id_t   b_id,
    output logic                   b_valid,
    input  logic                   b_ready
);

    import axi_mem_pkg::*;

    localparam int QPTR_W = $clog2(`NUM_SLOTS);

    xfer_t                  slots [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0]  done;
    axi_id_t                q_id [`NUM_SLOTS];
    logic [QPTR_W:0]        q_cnt;
    logic [QPTR_W-1:0]      ins_idx;
    axi_id_t                w_tgt;
    logic                   w_tgt_valid;
    logic                   tgt_last;
    logic                   w_fire;
    logic                   load;
    logic                   b_push;

    assign aw_ready = !slots[aw.id].valid;
    assign load     = aw_valid && aw_ready;

    // oldest queued transfer still waiting for data
    always_comb begin
        w_tgt_valid = 1'b0;
        w_tgt       = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (i < q_cnt && !done[q_id[i]]) begin
                w_tgt_valid = 1'b1;
                w_tgt       = q_id[i];
            end
        end
    end

    assign w_ready  = w_tgt_valid;
    assign w_fire   = w_valid && w_ready;
    assign tgt_last = (slots[w_tgt].cur == slots[w_tgt].len);
    assign wr_addr  = burst_addr(slots[w_tgt]);
    assign wr_data  = w.data;
    assign wr_strb  = w.strb;
    assign wr_en    = w_fire;

    assign b_push  = (q_cnt != '0) && done[q_id[0]] && (!b_valid || b_ready);
    assign ins_idx = b_push ? QPTR_W'(q_cnt - 1'b1) : QPTR_W'(q_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
            done <= '0;
        end else begin
            if (w_fire) begin
                slots[w_tgt].cur <= slots[w_tgt].cur + 8'd1;
                if (tgt_last) begin
                    done[w_tgt] <= 1'b1;
                end
            end
            if (b_push) begin
                slots[q_id[0]].valid <= 1'b0;
                done[q_id[0]]        <= 1'b0;
            end
            if (load) begin
                slots[aw.id] <= '{valid: 1'b1, addr: aw.addr, len: aw.len,
                                  cur: '0, burst: aw.burst};
                done[aw.id]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_cnt <= '0;
        end else begin
            q_cnt <= q_cnt + (QPTR_W + 1)'(load) - (QPTR_W + 1)'(b_push);
        end
    end

    // head leaves with its B, the new id lands behind the last entry
    always_ff @(posedge clk) begin
        if (b_push) begin
            for (int i = 0; i < `NUM_SLOTS - 1; i++) begin
                q_id[i] <= q_id[i+1];
            end
        end
        if (load) begin
            q_id[ins_idx] <= aw.id;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
        end else if (b_push) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (b_push) begin
            b_id <= q_id[0];
        end
    end

    a_wlast_match: assert property (@(posedge clk) disable iff (!rst_n)
        w_fire |-> (w.last == tgt_last));

    a_beat_has_slot: assert property (@(posedge clk) disable iff (!rst_n)
        w_fire |-> slots[w_tgt].valid);

endmodule

// File: verilog/mem_mmio.sv
/* Word-wide memory array and 8250-style serial stub
   decodes the address map for the read and write engines */
`include "axi_mem_macros.svh"

module mem_mmio (
    input  logic                      clk,
    input  logic                      rst_n,
    input  axi_mem_pkg::axi_addr_t    rd_addr,
    input  logic                      rd_en,
    output axi_mem_pkg::axi_data_t    rd_data,
    input  axi_mem_pkg::axi_addr_t    wr_addr,
    input  axi_mem_pkg::axi_data_t    wr_data,
    input  axi_mem_pkg::axi_strb_t    wr_strb,
    input  logic                      wr_en,
    output axi_mem_pkg::serial_byte_t tx_byte,
    output logic                      tx_valid,
    input  axi_mem_pkg::serial_byte_t rx_byte,
    input  logic                      rx_push
);

    import axi_mem_pkg::*;

    localparam int WORD_LSB = $clog2(`AXI_STRB_W);

    axi_data_t                  mem [2**`MEM_WORDS_LOG2];
    serial_byte_t               rx_data;
    logic                       rx_avail;
    logic [`MEM_WORDS_LOG2-1:0] rd_idx;
    logic [`MEM_WORDS_LOG2-1:0] wr_idx;
    logic                       rd_is_mem;
    logic                       wr_is_mem;
    logic                       serial_rd;
    logic                       serial_wr;

    // bit 31 selects memory, everything below is MMIO
    assign rd_is_mem = rd_addr[`AXI_ADDR_W-1];
    assign wr_is_mem = wr_addr[`AXI_ADDR_W-1];
    assign rd_idx    = rd_addr[WORD_LSB +: `MEM_WORDS_LOG2];
    assign wr_idx    = wr_addr[WORD_LSB +: `MEM_WORDS_LOG2];
    assign serial_rd = rd_en && (rd_addr == `SERIAL_ADDR);
    assign serial_wr = wr_en && (wr_addr == `SERIAL_ADDR) && wr_strb[0];

    always_comb begin
        rd_data = '0;
        if (rd_is_mem) begin
            rd_data = mem[rd_idx];
        end else if (rd_addr == `SERIAL_ADDR) begin
            rd_data = axi_data_t'(rx_data);
        end else if (rd_addr == `SERIAL_STAT_ADDR) begin
            rd_data = axi_data_t'(8'h60 | serial_byte_t'(rx_avail));
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_is_mem) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            rx_avail <= 1'b0;
        end else begin
            tx_valid <= serial_wr;
            // a new byte wins over a read in the same cycle
            if (rx_push) begin
                rx_avail <= 1'b1;
            end else if (serial_rd) begin
                rx_avail <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (serial_wr) begin
            tx_byte <= {1'b0, wr_data[6:0]};
        end
        if (rx_push) begin
            rx_data <= rx_byte;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_en && rd_is_mem) |-> (rd_addr[WORD_LSB-1:0] == '0)) and
        ((wr_en && wr_is_mem) |-> (wr_addr[WORD_LSB-1:0] == '0)));

endmodule

// File: verilog/axi_mem_top.sv
/* AXI4 memory slave top level
   request buffers, read and write engines and the memory/MMIO block */
module axi_mem_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  axi_mem_pkg::ax_req_t      aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  axi_mem_pkg::w_beat_t      w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output axi_mem_pkg::axi_id_t      b_id,
    output logic                      b_valid,
    input  logic                      b_ready,
    input  axi_mem_pkg::ax_req_t      ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output axi_mem_pkg::r_beat_t      r,
    output logic                      r_valid,
    input  logic                      r_ready,
    output axi_mem_pkg::serial_byte_t tx_byte,
    output logic                      tx_valid,
    input  axi_mem_pkg::serial_byte_t rx_byte,
    input  logic                      rx_push
);

    import axi_mem_pkg::*;

    ax_req_t   aw_buf;
    logic      aw_buf_valid;
    logic      aw_buf_ready;
    w_beat_t   w_buf;
    logic      w_buf_valid;
    logic      w_buf_ready;
    ax_req_t   ar_buf;
    logic      ar_buf_valid;
    logic      ar_buf_ready;
    axi_addr_t rd_addr;
    logic      rd_en;
    axi_data_t rd_data;
    axi_addr_t wr_addr;
    axi_data_t wr_data;
    axi_strb_t wr_strb;
    logic      wr_en;

    req_fifo #(.WIDTH($bits(ax_req_t))) u_aw_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (aw),
        .in_valid  (aw_valid),
        .in_ready  (aw_ready),
        .out_data  (aw_buf),
        .out_valid (aw_buf_valid),
        .out_ready (aw_buf_ready)
    );

    req_fifo #(.WIDTH($bits(w_beat_t))) u_w_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (w),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .out_data  (w_buf),
        .out_valid (w_buf_valid),
        .out_ready (w_buf_ready)
    );

    req_fifo #(.WIDTH($bits(ax_req_t))) u_ar_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (ar),
        .in_valid  (ar_valid),
        .in_ready  (ar_ready),
        .out_data  (ar_buf),
        .out_valid (ar_buf_valid),
        .out_ready (ar_buf_ready)
    );

    read_engine u_read (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (ar_buf),
        .ar_valid (ar_buf_valid),
        .ar_ready (ar_buf_ready),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    write_engine u_write (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw       (aw_buf),
        .aw_valid (aw_buf_valid),
        .aw_ready (aw_buf_ready),
        .w        (w_buf),
        .w_valid  (w_buf_valid),
        .w_ready  (w_buf_ready),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .wr_en    (wr_en),
        .b_id     (b_id),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    mem_mmio u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .wr_en    (wr_en),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .rx_byte  (rx_byte),
        .rx_push  (rx_push)
    );

endmodule

// File: sim/tb_axi_mem.sv
/* Testbench for the AXI memory slave
   drives bursts and serial traffic, checks against a reference memory model */
`include "axi_mem_macros.svh"

module tb_axi_mem;

    timeunit 1ns;
    timeprecision 100ps;

    import axi_mem_pkg::*;

    localparam int BUS_BYTES  = `AXI_DATA_W / 8;
    localparam int WORD_LSB   = $clog2(BUS_BYTES);
    localparam int RESP_LIMIT = 300;
    localparam int MAX_CYCLES = 4000;

    logic         clk;
    logic         rst_n;
    ax_req_t      aw;
    logic         aw_valid;
    logic         aw_ready;
    w_beat_t      w;
    logic         w_valid;
    logic         w_ready;
    axi_id_t      b_id;
    logic         b_valid;
    logic         b_ready;
    ax_req_t      ar;
    logic         ar_valid;
    logic         ar_ready;
    r_beat_t      r;
    logic         r_valid;
    logic         r_ready;
    serial_byte_t tx_byte;
    logic         tx_valid;
    serial_byte_t rx_byte;
    logic         rx_push;

    // reference model and collected responses
    axi_data_t    ref_mem [int];
    serial_byte_t exp_tx[$];
    w_beat_t      w_plan[$];
    r_beat_t      r_got[$];
    r_beat_t      taken[$];
    axi_id_t      b_got[$];
    serial_byte_t tx_got[$];
    bit           bp_on;
    int           errors;
    int           pass_count;
    int           fail_count;
    int           cycles;

    axi_mem_top i_axi_mem_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_id     (b_id),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .rx_byte  (rx_byte),
        .rx_push  (rx_push)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // response side ready goes random only during the back-pressure test
    initial begin
        r_ready = 1'b1;
        b_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (bp_on) begin
                r_ready = 1'($urandom_range(0, 1));
                b_ready = 1'($urandom_range(0, 1));
            end else begin
                r_ready = 1'b1;
                b_ready = 1'b1;
            end
        end
    end

    // handshakes sampled mid-cycle, where everything is stable
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && r_valid && r_ready) begin
                r_got.push_back(r);
            end
            if (rst_n && b_valid && b_ready) begin
                b_got.push_back(b_id);
            end
            if (rst_n && tx_valid) begin
                tx_got.push_back(tx_byte);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    function automatic axi_addr_t expected_addr(input axi_addr_t start, input beat_cnt_t len,
                                                input burst_t bt, input int beat);
        axi_addr_t span;
        axi_addr_t base;
        span = (axi_addr_t'(len) + 1) * BUS_BYTES;
        base = start - (start % span);
        case (bt)
            FIXED:   expected_addr = start;
            WRAP:    expected_addr = base + ((start - base + axi_addr_t'(beat) * BUS_BYTES) % span);
            default: expected_addr = start + axi_addr_t'(beat) * BUS_BYTES;
        endcase
    endfunction

    function automatic void ref_write(input axi_addr_t a, input axi_data_t d, input axi_strb_t s);
        int        key;
        axi_data_t word;
        if (a[`AXI_ADDR_W-1]) begin
            key  = int'(a[WORD_LSB +: `MEM_WORDS_LOG2]);
            word = ref_mem.exists(key) ? ref_mem[key] : 'x;
            for (int i = 0; i < BUS_BYTES; i++) begin
                if (s[i]) begin
                    word[8*i +: 8] = d[8*i +: 8];
                end
            end
            ref_mem[key] = word;
        end else if (a == `SERIAL_ADDR && s[0]) begin
            exp_tx.push_back(d[7:0] & 8'h7f);
        end
    endfunction

    function automatic axi_data_t ref_read(input axi_addr_t a);
        int key;
        key = int'(a[WORD_LSB +: `MEM_WORDS_LOG2]);
        ref_read = ref_mem.exists(key) ? ref_mem[key] : 'x;
    endfunction

    function automatic ax_req_t make_req(input int id, input axi_addr_t addr, input int len,
                                         input burst_t bt);
        make_req = '{id: axi_id_t'(id), addr: addr, len: beat_cnt_t'(len), burst: bt,
                     lock: 1'b0, cache: 4'h0};
    endfunction

    task automatic check_data(input axi_data_t got, input axi_data_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input serial_byte_t got, input serial_byte_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // senders are entered 1 ns after a rising edge and return at the same phase
    task automatic send_aw(input ax_req_t req);
        aw       = req;
        aw_valid = 1'b1;
        do @(negedge clk); while (!aw_ready);
        @(posedge clk);
        #1;
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input w_beat_t beat);
        w       = beat;
        w_valid = 1'b1;
        do @(negedge clk); while (!w_ready);
        @(posedge clk);
        #1;
        w_valid = 1'b0;
    endtask

    task automatic send_ar(input ax_req_t req);
        ar       = req;
        ar_valid = 1'b1;
        do @(negedge clk); while (!ar_ready);
        @(posedge clk);
        #1;
        ar_valid = 1'b0;
    endtask

    task automatic plan_write(input ax_req_t req, input bit rand_strb);
        w_beat_t beat;
        for (int i = 0; i <= int'(req.len); i++) begin
            beat.data = {$urandom, $urandom};
            beat.strb = rand_strb ? axi_strb_t'($urandom) : '1;
            beat.last = (i == int'(req.len));
            w_plan.push_back(beat);
            ref_write(expected_addr(req.addr, req.len, req.burst, i), beat.data, beat.strb);
        end
    endtask

    task automatic push_w_plan();
        while (w_plan.size() > 0) begin
            send_w(w_plan.pop_front());
        end
    endtask

    task automatic wait_b(input axi_id_t id);
        int n;
        n = 0;
        while (b_got.size() == 0 && n < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (b_got.size() == 0) begin
            $display("no B response arrived for id %0d", id);
            errors++;
        end else begin
            check_id(b_got.pop_front(), id, "B id");
        end
    endtask

    function automatic int beats_for(input axi_id_t id);
        int n;
        n = 0;
        foreach (r_got[i]) begin
            if (r_got[i].id == id) begin
                n++;
            end
        end
        return n;
    endfunction

    // moves the first n beats of one id into taken
    task automatic take_r(input axi_id_t id, input int n, output bit ok);
        int k;
        int i;
        k = 0;
        while (beats_for(id) < n && k < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            k++;
        end
        ok = (beats_for(id) >= n);
        if (!ok) begin
            $display("R response for id %0d is missing beats", id);
            errors++;
        end
        taken.delete();
        i = 0;
        while (ok && i < r_got.size()) begin
            if (r_got[i].id == id && taken.size() < n) begin
                taken.push_back(r_got[i]);
                r_got.delete(i);
            end else begin
                i++;
            end
        end
    endtask

    task automatic check_r_stream(input ax_req_t req);
        int        n;
        bit        ok;
        axi_addr_t a;
        n = int'(req.len) + 1;
        take_r(req.id, n, ok);
        for (int i = 0; ok && i < n; i++) begin
            a = expected_addr(req.addr, req.len, req.burst, i);
            check_data(taken[i].data, ref_read(a),
                       $sformatf("id %0d beat %0d at %h", req.id, i, a));
            if (taken[i].last !== (i == n - 1)) begin
                $display("[FAIL] %0t id %0d beat %0d: last is %b", $time, req.id, i,
                         taken[i].last);
                errors++;
            end
        end
    endtask

    task automatic write_one(input ax_req_t req, input bit rand_strb);
        plan_write(req, rand_strb);
        fork
            send_aw(req);
            push_w_plan();
        join
        wait_b(req.id);
    endtask

    task automatic read_single(input axi_addr_t addr, output axi_data_t data);
        bit ok;
        send_ar(make_req(0, addr, 0, INCR));
        take_r(axi_id_t'(0), 1, ok);
        data = ok ? taken[0].data : 'x;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic run_incr();
        ax_req_t req;
        int      e;
        e = errors;
        for (int k = 0; k < 4; k++) begin
            req = make_req($urandom_range(0, 3), 32'h8000_0000 + k * 32'h100,
                           $urandom_range(0, 15), INCR);
            write_one(req, 1'b0);
            send_ar(req);
            check_r_stream(req);
        end
        finish_test("incr bursts", e);
    endtask

    task automatic run_strobe();
        ax_req_t req;
        int      e;
        e = errors;
        req = make_req(1, 32'h8000_0400, 5, INCR);
        write_one(req, 1'b0);
        write_one(req, 1'b1);
        send_ar(req);
        check_r_stream(req);
        finish_test("byte strobes", e);
    endtask

    task automatic run_wrap_fixed();
        ax_req_t fill;
        ax_req_t wrap4;
        int      e;
        e = errors;
        fill  = make_req(2, 32'h8000_0600, 15, INCR);
        wrap4 = make_req(3, 32'h8000_0628, 3, WRAP);
        write_one(fill, 1'b0);
        write_one(wrap4, 1'b0);
        write_one(make_req(0, 32'h8000_0648, 7, WRAP), 1'b0);
        write_one(make_req(1, 32'h8000_0608, 2, FIXED), 1'b0);
        // whole 16-word window, then the wrap burst read back as a wrap
        send_ar(fill);
        check_r_stream(fill);
        send_ar(wrap4);
        check_r_stream(wrap4);
        finish_test("wrap and fixed bursts", e);
    endtask

    task automatic run_serial();
        axi_data_t    d;
        serial_byte_t rx;
        int           e;
        int           n;
        e = errors;
        write_one(make_req(0, `SERIAL_ADDR, 0, INCR), 1'b0);
        n = 0;
        while (tx_got.size() == 0 && n < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (tx_got.size() == 0 || exp_tx.size() == 0) begin
            $display("serial write produced no transmit byte");
            errors++;
        end else begin
            check_byte(tx_got.pop_front(), exp_tx.pop_front(), "tx byte");
        end
        rx      = serial_byte_t'($urandom);
        rx_byte = rx;
        rx_push = 1'b1;
        @(posedge clk);
        #1;
        rx_push = 1'b0;
        read_single(`SERIAL_STAT_ADDR, d);
        check_data(d, 64'h61, "status with byte waiting");
        read_single(`SERIAL_ADDR, d);
        check_byte(d[7:0], rx, "rx byte");
        check_data(d, axi_data_t'(rx), "rx data word");
        read_single(`SERIAL_STAT_ADDR, d);
        check_data(d, 64'h60, "status after data read");
        read_single(32'h2000_0000, d);
        check_data(d, '0, "unmapped MMIO read");
        finish_test("serial port", e);
    endtask

    task automatic run_backpressure();
        axi_id_t ids [4];
        ax_req_t reqs [4];
        axi_id_t tmp;
        int      j;
        int      e;
        e = errors;
        bp_on = 1'b1;
        for (int i = 0; i < 4; i++) begin
            ids[i] = axi_id_t'(i);
        end
        for (int i = 3; i > 0; i--) begin
            j      = $urandom_range(0, i);
            tmp    = ids[i];
            ids[i] = ids[j];
            ids[j] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            reqs[i] = make_req(ids[i], 32'h8000_0000 + ids[i] * 32'h100 +
                               $urandom_range(0, 7) * BUS_BYTES, $urandom_range(0, 7), INCR);
            plan_write(reqs[i], 1'b1);
        end
        fork
            for (int i = 0; i < 4; i++) begin
                send_aw(reqs[i]);
            end
            push_w_plan();
        join
        // B ids must follow AW order
        for (int i = 0; i < 4; i++) begin
            wait_b(ids[i]);
        end
        for (int i = 0; i < 4; i++) begin
            send_ar(reqs[i]);
        end
        for (int i = 0; i < 4; i++) begin
            check_r_stream(reqs[i]);
        end
        bp_on = 1'b0;
        finish_test("back-pressure and ordering", e);
    endtask

    initial begin
        void'($urandom(71));
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        bp_on      = 1'b0;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        rx_byte    = '0;
        rx_push    = 1'b0;
        rst_n      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        run_incr();
        run_strobe();
        run_wrap_fixed();
        run_serial();
        run_backpressure();
        if (r_got.size() != 0 || b_got.size() != 0) begin
            $display("unexpected responses left over after the last test");
            errors++;
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
verilog/axi_mem_pkg.sv
verilog/req_fifo.sv
verilog/read_engine.sv
verilog/write_engine.sv
verilog/mem_mmio.sv
verilog/axi_mem_top.sv
sim/tb_axi_mem.sv
